//--- logic/posit_div_pkg.sv
// Division sequencing types; quotient sized for one hidden, guard and normalization bit only
`default_nettype none

package posit_div_pkg;

    ////////////////////
    // Sequencer
    ////////////////////

    // Load, iterate, normalize
    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        FINISH
    } div_state_t;

    ////////////////////
    // Quotient sizing
    ////////////////////

    // Hidden bit, fraction, guard, normalization spare
    localparam int QUOT_W = posit_fmt_pkg::FRAC_W + 3;

    // One quotient bit per restoring step
    localparam int DIV_STEPS = QUOT_W;

    // Unrounded quotient handed to the encoder
    typedef struct packed {
        logic                                        sign;
        logic                                        is_zero;
        logic                                        is_nar;
        logic signed [posit_fmt_pkg::SCALE_W-1:0]    scale;
        // Leading one in MSB after FINISH
        logic [QUOT_W-1:0]                           mant;
        // OR of the final remainder
        logic                                        sticky;
    } quotient_t;

endpackage

`default_nettype wire

//--- logic/posit_div_top.sv
// Posit16 divider top; start is ignored while busy, done is a pulse with no back-pressure
`timescale 1ns/1ps
`default_nettype none

module posit_div_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [posit_fmt_pkg::POSIT_N-1:0]     dividend,
    input  logic [posit_fmt_pkg::POSIT_N-1:0]     divisor,
    output logic                                  busy,
    output logic                                  done,
    output logic [posit_fmt_pkg::POSIT_N-1:0]     quotient
);

    // Two quotient bits per cycle, 11-cycle start-to-done
    localparam int BITS_PER_CYCLE = 2;

    posit_fmt_pkg::posit_fields_t  a_fields;
    posit_fmt_pkg::posit_fields_t  b_fields;
    logic                          fields_valid;
    posit_div_pkg::quotient_t      q_info;
    logic                          q_valid;
    logic                          start_acc;

    // Starts during an operation are dropped
    assign start_acc = start & ~busy;

    posit_field_decode posit_field_decode_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start_acc),
        .dividend     (dividend),
        .divisor      (divisor),
        .a_fields     (a_fields),
        .b_fields     (b_fields),
        .fields_valid (fields_valid)
    );

    posit_mant_divider #(
        .BITS_PER_CYCLE (BITS_PER_CYCLE)
    ) posit_mant_divider_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .fields_valid (fields_valid),
        .a_fields     (a_fields),
        .b_fields     (b_fields),
        .q_info       (q_info),
        .q_valid      (q_valid),
        .busy         (busy)
    );

    posit_round_encode posit_round_encode_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .q_valid  (q_valid),
        .q_info   (q_info),
        .quotient (quotient),
        .done     (done)
    );

endmodule

`default_nettype wire

//--- logic/posit_field_decode.sv
// Operand decode; expects start only when the divider is idle, holds fields until the next start
`timescale 1ns/1ps
`default_nettype none

module posit_field_decode (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [posit_fmt_pkg::POSIT_N-1:0]     dividend,
    input  logic [posit_fmt_pkg::POSIT_N-1:0]     divisor,
    output posit_fmt_pkg::posit_fields_t          a_fields,
    output posit_fmt_pkg::posit_fields_t          b_fields,
    output logic                                  fields_valid
);

    localparam int N  = posit_fmt_pkg::POSIT_N;
    localparam int ES = posit_fmt_pkg::POSIT_ES;
    localparam int FW = posit_fmt_pkg::FRAC_W;
    localparam int KW = posit_fmt_pkg::K_W;

    ////////////////////
    // Field extraction
    ////////////////////

    // Split one posit word into sign, regime, exponent and fraction
    function automatic posit_fmt_pkg::posit_fields_t decode_posit(input logic [N-1:0] p);
        logic [N-1:0]                  mag;
        logic [N-2:0]                  body;
        logic [N-2:0]                  rest;
        logic                          rbit;
        logic                          run_end;
        int                            run;
        posit_fmt_pkg::posit_fields_t  f;

        // Negative words decode from their magnitude
        mag  = p[N-1] ? (~p + 1'b1) : p;
        body = mag[N-2:0];
        rbit = body[N-2];

        // Leading run detector
        // Counts identical bits from the MSB until the terminator
        run     = 0;
        run_end = 1'b0;
        for (int i = N - 2; i >= 0; i--)
        begin
            if (!run_end && (body[i] == rbit))
                run = run + 1;
            else
                run_end = 1'b1;
        end

        // Drop run and terminator, exponent lands at the top
        rest = body << (run + 1);

        f.sign    = p[N-1];
        f.is_zero = (p == posit_fmt_pkg::POSIT_ZERO);
        f.is_nar  = (p == posit_fmt_pkg::POSIT_NAR);
        // Run of ones gives k = run - 1, run of zeros gives k = -run
        f.k       = rbit ? KW'(run - 1) : KW'(-run);
        f.exp     = rest[N-2 -: ES];
        // Short words leave zeros in the low fraction bits
        f.frac    = {1'b1, rest[N-2-ES -: FW]};
        return f;
    endfunction

    ////////////////////
    // Registers
    ////////////////////

    // Valid pulse one cycle after start
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            fields_valid <= 1'b0;
        else
            fields_valid <= start;
    end

    // Payload, held between operations
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            a_fields <= decode_posit(dividend);
            b_fields <= decode_posit(divisor);
        end
    end

endmodule

`default_nettype wire

//--- logic/posit_fmt_pkg.sv
// Posit format constants for N = 16, es = 1 only; struct widths are fixed here, not per instance
`default_nettype none

package posit_fmt_pkg;

    ////////////////////
    // Format widths
    ////////////////////

    // Word width and exponent field width
    localparam int POSIT_N  = 16;
    localparam int POSIT_ES = 1;

    // Widest fraction field, hidden bit excluded
    localparam int FRAC_W = POSIT_N - POSIT_ES - 2;

    // Signed regime value, holds -(N-1) .. N-2
    localparam int K_W = $clog2(POSIT_N) + 1;

    // Quotient scale before saturation
    // Covers difference of two extreme scales plus one normalization step
    localparam int SCALE_W = 8;

    ////////////////////
    // Special encodings
    ////////////////////

    localparam logic [POSIT_N-1:0] POSIT_ZERO   = '0;
    localparam logic [POSIT_N-1:0] POSIT_NAR    = {1'b1, {(POSIT_N-1){1'b0}}};
    // Regime of all ones
    localparam logic [POSIT_N-1:0] POSIT_MAXPOS = {1'b0, {(POSIT_N-1){1'b1}}};
    // Longest zero run, terminator in LSB
    localparam logic [POSIT_N-1:0] POSIT_MINPOS = {{(POSIT_N-1){1'b0}}, 1'b1};

    ////////////////////
    // Decoded operand
    ////////////////////

    // Magnitude fields taken after two's complement of negative words
    typedef struct packed {
        logic                  sign;
        logic                  is_zero;
        logic                  is_nar;
        logic signed [K_W-1:0] k;
        logic [POSIT_ES-1:0]   exp;
        // Hidden one in MSB
        logic [FRAC_W:0]       frac;
    } posit_fields_t;

endpackage

`default_nettype wire

//--- logic/posit_mant_divider.sv
// Restoring fraction divider; one operation at a time, BITS_PER_CYCLE of 1 or 2 dividing DIV_STEPS
`timescale 1ns/1ps
`default_nettype none

module posit_mant_divider #(
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              fields_valid,
    input  posit_fmt_pkg::posit_fields_t      a_fields,
    input  posit_fmt_pkg::posit_fields_t      b_fields,
    output posit_div_pkg::quotient_t          q_info,
    output logic                              q_valid,
    output logic                              busy
);

    localparam int QW     = posit_div_pkg::QUOT_W;
    localparam int MW     = posit_fmt_pkg::FRAC_W + 1;
    localparam int SW     = posit_fmt_pkg::SCALE_W;
    localparam int ES     = posit_fmt_pkg::POSIT_ES;
    localparam int CYCLES = (posit_div_pkg::DIV_STEPS + BITS_PER_CYCLE - 1) / BITS_PER_CYCLE;
    localparam int CNT_W  = $clog2(CYCLES + 1);

    posit_div_pkg::div_state_t  state;
    logic [CNT_W-1:0]           step_cnt;

    // Remainder one bit wider than the divisor, stays below twice the divisor
    logic [MW:0]                rem;
    logic [MW:0]                rem_nxt;
    logic [MW-1:0]              dsr;
    logic [QW-1:0]              quo;
    logic [QW-1:0]              quo_nxt;
    logic signed [SW-1:0]       scale_a;
    logic signed [SW-1:0]       scale_b;

    ////////////////////
    // Scale and steps
    ////////////////////

    // Scale = k * 2^es + exp
    always_comb
    begin
        scale_a = (SW'(a_fields.k) <<< ES) + SW'(a_fields.exp);
        scale_b = (SW'(b_fields.k) <<< ES) + SW'(b_fields.exp);
    end

    // BITS_PER_CYCLE restoring steps
    always_comb
    begin
        rem_nxt = rem;
        quo_nxt = quo;
        for (int i = 0; i < BITS_PER_CYCLE; i++)
        begin
            // Trial subtract, keep result only when it fits
            quo_nxt = {quo_nxt[QW-2:0], (rem_nxt >= {1'b0, dsr})};
            if (quo_nxt[0])
                rem_nxt = rem_nxt - {1'b0, dsr};
            rem_nxt = rem_nxt << 1;
        end
    end

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= posit_div_pkg::IDLE;
            step_cnt <= '0;
            q_valid  <= 1'b0;
        end
        else
        begin
            q_valid <= 1'b0;
            case (state)
                posit_div_pkg::IDLE:
                begin
                    if (fields_valid)
                    begin
                        state    <= posit_div_pkg::DIVIDE;
                        step_cnt <= '0;
                    end
                end
                posit_div_pkg::DIVIDE:
                begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(CYCLES - 1))
                        state <= posit_div_pkg::FINISH;
                end
                posit_div_pkg::FINISH:
                begin
                    state   <= posit_div_pkg::IDLE;
                    q_valid <= 1'b1;
                end
                default:
                    state <= posit_div_pkg::IDLE;
            endcase
        end
    end

    // Datapath, specials run the same count
    always_ff @(posedge clk)
    begin
        if ((state == posit_div_pkg::IDLE) && fields_valid)
        begin
            rem            <= {1'b0, a_fields.frac};
            dsr            <= b_fields.frac;
            quo            <= '0;
            q_info.sign    <= a_fields.sign ^ b_fields.sign;
            q_info.scale   <= scale_a - scale_b;
            // x/0 and NaR inputs give NaR
            q_info.is_nar  <= a_fields.is_nar | b_fields.is_nar | b_fields.is_zero;
            q_info.is_zero <= a_fields.is_zero & ~(a_fields.is_nar | b_fields.is_nar |
                                                   b_fields.is_zero);
        end
        else if (state == posit_div_pkg::DIVIDE)
        begin
            rem <= rem_nxt;
            quo <= quo_nxt;
        end
        else if (state == posit_div_pkg::FINISH)
        begin
            // Quotient of two [1,2) values is above 1/2, at most one shift
            if (quo[QW-1])
                q_info.mant <= quo;
            else
            begin
                q_info.mant  <= {quo[QW-2:0], 1'b0};
                q_info.scale <= q_info.scale - 1'b1;
            end
            q_info.sticky <= |rem;
        end
    end

    // High from the fields_valid cycle through the q_valid cycle
    assign busy = fields_valid || (state != posit_div_pkg::IDLE) || q_valid;

    ////////////////////
    // Checks
    ////////////////////

    // Upstream must hold off while an operation is in flight
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        fields_valid |-> (state == posit_div_pkg::IDLE));

    // Single-cycle result strobe
    a_q_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid |=> !q_valid);

endmodule

`default_nettype wire

//--- logic/posit_round_encode.sv
// Round to nearest even and re-encode; saturates at maxpos/minpos, never rounds to zero or NaR
`timescale 1ns/1ps
`default_nettype none

module posit_round_encode (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  q_valid,
    input  posit_div_pkg::quotient_t              q_info,
    output logic [posit_fmt_pkg::POSIT_N-1:0]     quotient,
    output logic                                  done
);

    localparam int N  = posit_fmt_pkg::POSIT_N;
    localparam int ES = posit_fmt_pkg::POSIT_ES;
    localparam int QW = posit_div_pkg::QUOT_W;
    localparam int SW = posit_fmt_pkg::SCALE_W;
    // Terminator, exponent, fraction, then room for the regime shift
    localparam int FW = N + ES + QW - 1;

    // Longest regime that still fits the word
    localparam logic signed [SW-1:0] K_MAX = SW'(N - 2);
    localparam logic signed [SW-1:0] K_MIN = -SW'(N - 2);

    logic signed [SW-1:0]  k_raw;
    logic signed [SW-1:0]  k_c;
    logic [ES-1:0]         e;
    logic                  rbit;
    logic [SW-1:0]         run;
    logic [FW-1:0]         wide;
    logic [FW-1:0]         shifted;
    logic [N-2:0]          body;
    logic                  guard;
    logic                  sticky;
    logic                  last;
    logic                  full;
    logic                  rnd;
    logic [N-1:0]          mag;
    logic [N-1:0]          word;

    ////////////////////
    // Encode
    ////////////////////

    always_comb
    begin
        // Scale splits into regime and exponent
        k_raw = q_info.scale >>> ES;
        e     = q_info.scale[ES-1:0];

        // Clamp keeps the shift inside the field
        if (k_raw > K_MAX)
            k_c = K_MAX;
        else if (k_raw < K_MIN)
            k_c = K_MIN;
        else
            k_c = k_raw;

        // Ones run for k >= 0, zeros run otherwise
        rbit = ~k_c[SW-1];
        run  = rbit ? SW'(k_c + 1'b1) : SW'(-k_c);

        // Terminator is the inverse of the run bit
        wide    = {~rbit, e, q_info.mant[QW-2:0], {(N-1){1'b0}}};
        shifted = (wide >> run) | (rbit ? ~({FW{1'b1}} >> run) : '0);

        body   = shifted[FW-1 -: N-1];
        guard  = shifted[FW-N];
        sticky = (|shifted[FW-N-1:0]) | q_info.sticky;
        last   = body[0];

        // Regime alone fills the word
        full = (k_c == K_MAX) || (k_c == K_MIN);

        // Nearest, ties to even
        rnd = guard & (sticky | last) & ~full;
        mag = {1'b0, body + (N-1)'(rnd)};

        // Out of range saturates
        if (k_raw > K_MAX)
            mag = posit_fmt_pkg::POSIT_MAXPOS;
        else if (k_raw < K_MIN)
            mag = posit_fmt_pkg::POSIT_MINPOS;

        // Negative result as two's complement
        word = q_info.sign ? (~mag + 1'b1) : mag;

        // Specials bypass arithmetic
        if (q_info.is_nar)
            word = posit_fmt_pkg::POSIT_NAR;
        else if (q_info.is_zero)
            word = posit_fmt_pkg::POSIT_ZERO;
    end

    ////////////////////
    // Output registers
    ////////////////////

    // Result held until the next operation completes
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            quotient <= posit_fmt_pkg::POSIT_ZERO;
            done     <= 1'b0;
        end
        else
        begin
            done <= q_valid;
            if (q_valid)
                quotient <= word;
        end
    end

    // Arithmetic path never produces the NaR pattern
    a_no_false_nar: assert property (@(posedge clk) disable iff (!rst_n)
        (q_valid && !q_info.is_nar) |=> (done && (quotient != posit_fmt_pkg::POSIT_NAR)));

endmodule

`default_nettype wire

//--- project.f
logic/posit_fmt_pkg.sv
logic/posit_div_pkg.sv
logic/posit_field_decode.sv
logic/posit_mant_divider.sv
logic/posit_round_encode.sv
logic/posit_div_top.sv
testbench/posit_div_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the posit divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module posit_div_tb \
    -Mdir obj_dir \
    -o posit_div_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/posit_div_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'Result: PASSED'; then
    exit 0
else
    exit 1
fi

//--- testbench/posit_div_tb.sv
// Posit16 divider testbench; assumes an 11-cycle start-to-done latency and needs Verilator --timing --assert
`timescale 1ns/1ps
`default_nettype none

module posit_div_tb;

    localparam int N            = posit_fmt_pkg::POSIT_N;
    localparam int RESET_CYCLES = 10;
    // Edges from the start edge to the edge that raises done
    localparam int LATENCY      = 11;
    // Specials 5, identity 32, exact 3, sign 9, saturation and rounding 4, overlap 1
    localparam int NUM_OPS      = 54;
    // Under 16 cycles per operation, plus the idle tail of the overlap test
    localparam int TIMEOUT_CYCLES = NUM_OPS * 16 + RESET_CYCLES + 16;

    localparam logic [N-1:0] POSIT_ONE = 16'h4000;

    // One division with its expected result
    typedef struct packed {
        logic [N-1:0] a;
        logic [N-1:0] b;
        logic [N-1:0] q;
    } div_case_t;

    logic          clk;
    logic          rst_n;
    logic          start;
    logic [N-1:0]  dividend;
    logic [N-1:0]  divisor;
    logic          busy;
    logic          done;
    logic [N-1:0]  quotient;

    logic [N-1:0]  exp_word;
    string         test_name;
    int            since_start;
    int            cycle_cnt;
    int            value_errors;
    int            timing_errors;
    int            reset_errors;
    div_case_t     exact_cases [3];

    posit_div_top posit_div_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .done     (done),
        .quotient (quotient)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Bookkeeping
    ////////////////////

    // Cycles since the DUT took a start, zero when idle
    always @(posedge clk)
    begin
        if (!rst_n)
            since_start <= 0;
        else if (start && !busy)
            since_start <= 1;
        else if (done)
            since_start <= 0;
        else if (since_start != 0)
            since_start <= since_start + 1;
    end

    // Hard stop
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run exceeded %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (!busy && !done && quotient == posit_fmt_pkg::POSIT_ZERO))
    else
    begin
        reset_errors++;
        $display("Outputs not cleared by reset: busy %b done %b quotient %h",
                 busy, done, quotient);
    end

    // Busy through the whole operation, no early done
    a_busy_span: assert property (@(posedge clk) disable iff (!rst_n)
        (since_start >= 1 && since_start <= LATENCY) |-> (busy && !done))
    else
    begin
        timing_errors++;
        $display("Busy dropped or done came early in test %s", test_name);
    end

    // done is raised on edge LATENCY and seen one sample later
    a_done_time: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (since_start == LATENCY + 1))
    else
    begin
        timing_errors++;
        $display("Unexpected done pulse in test %s", test_name);
    end

    a_done_arrives: assert property (@(posedge clk) disable iff (!rst_n)
        (since_start == LATENCY + 1) |-> done)
    else
    begin
        timing_errors++;
        $display("Done missing %0d cycles after start in test %s", LATENCY, test_name);
    end

    a_quotient: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (quotient == exp_word))
    else
    begin
        value_errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp_word, quotient);
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Two's complement gives the negated posit
    function automatic logic [N-1:0] negate_word(input logic [N-1:0] w);
        return ~w + 1'b1;
    endfunction

    function automatic logic [N-1:0] random_nonspecial();
        logic [N-1:0] w;
        w = N'($urandom());
        while (w == posit_fmt_pkg::POSIT_ZERO || w == posit_fmt_pkg::POSIT_NAR)
            w = N'($urandom());
        return w;
    endfunction

    // One start pulse, then wait for done
    task automatic issue_division(input string name, input logic [N-1:0] a,
                                  input logic [N-1:0] b, input logic [N-1:0] q);
        @(posedge clk);
        dividend  <= a;
        divisor   <= b;
        exp_word  <= q;
        test_name <= name;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (done !== 1'b1)
            @(posedge clk);
    endtask

    // Either sign flip negates, both cancel
    task automatic divide_signed_variants(input div_case_t c);
        issue_division("sign -a/b", negate_word(c.a), c.b, negate_word(c.q));
        issue_division("sign a/-b", c.a, negate_word(c.b), negate_word(c.q));
        issue_division("sign -a/-b", negate_word(c.a), negate_word(c.b), c.q);
    endtask

    // Second start lands mid-operation and must be dropped
    task automatic divide_with_ignored_start();
        @(posedge clk);
        dividend  <= 16'h6400;
        divisor   <= 16'h5800;
        exp_word  <= 16'h5000;
        test_name <= "overlap start";
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (3) @(posedge clk);
        dividend <= 16'h4000;
        divisor  <= 16'h6000;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (done !== 1'b1)
            @(posedge clk);
        // Window where a second done would show up
        repeat (16) @(posedge clk);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin
        logic [N-1:0] x;
        int           total;

        clk           = 1'b0;
        rst_n         = 1'b0;
        start         = 1'b0;
        dividend      = '0;
        divisor       = '0;
        exp_word      = '0;
        test_name     = "reset";
        cycle_cnt     = 0;
        value_errors  = 0;
        timing_errors = 0;
        reset_errors  = 0;
        void'($urandom(32'h4142_3c11));

        // 6/3, 4/2, 1/4
        exact_cases[0] = '{a: 16'h6400, b: 16'h5800, q: 16'h5000};
        exact_cases[1] = '{a: 16'h6000, b: 16'h5000, q: 16'h5000};
        exact_cases[2] = '{a: 16'h4000, b: 16'h6000, q: 16'h2000};

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Specials
        issue_division("x/0", POSIT_ONE, posit_fmt_pkg::POSIT_ZERO, posit_fmt_pkg::POSIT_NAR);
        issue_division("0/0", posit_fmt_pkg::POSIT_ZERO, posit_fmt_pkg::POSIT_ZERO,
                       posit_fmt_pkg::POSIT_NAR);
        issue_division("NaR/x", posit_fmt_pkg::POSIT_NAR, POSIT_ONE, posit_fmt_pkg::POSIT_NAR);
        issue_division("x/NaR", 16'h5800, posit_fmt_pkg::POSIT_NAR, posit_fmt_pkg::POSIT_NAR);
        issue_division("0/x", posit_fmt_pkg::POSIT_ZERO, 16'h5800, posit_fmt_pkg::POSIT_ZERO);

        // Identity and self-division
        for (int i = 0; i < 16; i++)
        begin
            x = random_nonspecial();
            issue_division("identity x/1", x, POSIT_ONE, x);
            issue_division("self x/x", x, x, POSIT_ONE);
        end

        for (int i = 0; i < 3; i++)
            issue_division("exact", exact_cases[i].a, exact_cases[i].b, exact_cases[i].q);

        for (int i = 0; i < 3; i++)
            divide_signed_variants(exact_cases[i]);

        // Saturation and rounding
        issue_division("maxpos/minpos", posit_fmt_pkg::POSIT_MAXPOS,
                       posit_fmt_pkg::POSIT_MINPOS, posit_fmt_pkg::POSIT_MAXPOS);
        issue_division("minpos/maxpos", posit_fmt_pkg::POSIT_MINPOS,
                       posit_fmt_pkg::POSIT_MAXPOS, posit_fmt_pkg::POSIT_MINPOS);
        // 1/3 has 12 fraction bits 0101..., guard clear with sticky set, truncates
        issue_division("1/3", POSIT_ONE, 16'h5800, 16'h2555);
        // 1/6 has 11 fraction bits, guard and sticky both set, rounds up
        issue_division("1/6", POSIT_ONE, 16'h6400, 16'h1AAB);

        divide_with_ignored_start();

        repeat (4) @(posedge clk);
        total = value_errors + timing_errors + reset_errors;
        $display("Errors: value %0d, timing %0d, reset %0d", value_errors, timing_errors,
                 reset_errors);
        if (total == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
